// File: src/axi_lite_config.svh
`ifndef AXI_LITE_CONFIG_SVH
`define AXI_LITE_CONFIG_SVH

// Number of 32-bit registers in the bank.
// Index 0 is the read-only identification word.
`define AXI_REG_COUNT 16

// Width of the AW and AR byte addresses.
`define AXI_ADDR_WIDTH 32

// Value returned for a read of index 0.
`define AXI_ID_WORD 32'hA5C0_0101

`endif

// File: src/axi_lite_pkg.sv
`include "axi_lite_config.svh"

// Types shared by the bus interfaces, the slave, the top and the testbench.
package axi_lite_pkg;

    // Response codes as carried on BRESP and RRESP.
    // EXOKAY and DECERR are never produced by this peripheral.
    typedef enum logic [1:0] {
        OKAY   = 2'b00,  // Normal access.
        SLVERR = 2'b10   // Rejected by the register bank.
    } resp_t;

    // One bus data word.
    typedef logic [31:0] word_t;

    // Byte lane enables, one per byte of word_t.
    typedef logic [3:0] strb_t;

    // Byte address on AW and AR.
    typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;

endpackage

// File: src/axi_write_if.sv
`timescale 1ns/1ps

// Write address, write data and write response channels.
interface axi_write_if;

    axi_lite_pkg::addr_t awaddr;   // Byte address.
    logic                awvalid;
    logic                awready;

    axi_lite_pkg::word_t wdata;
    axi_lite_pkg::strb_t wstrb;    // Byte enables.
    logic                wvalid;
    logic                wready;

    axi_lite_pkg::resp_t bresp;    // OKAY or SLVERR.
    logic                bvalid;
    logic                bready;

    modport master (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  awready, wready, bresp, bvalid
    );

    modport slave (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output awready, wready, bresp, bvalid
    );

endinterface

// File: src/axi_read_if.sv
`timescale 1ns/1ps

// Read address and read data channels.
interface axi_read_if;

    axi_lite_pkg::addr_t araddr;   // Byte address.
    logic                arvalid;
    logic                arready;

    axi_lite_pkg::word_t rdata;
    axi_lite_pkg::resp_t rresp;    // OKAY or SLVERR.
    logic                rvalid;
    logic                rready;

    modport master (
        output araddr, arvalid, rready,
        input  arready, rdata, rresp, rvalid
    );

    modport slave (
        input  araddr, arvalid, rready,
        output arready, rdata, rresp, rvalid
    );

endinterface

// File: src/axi_slave.sv
`timescale 1ns/1ps

module axi_slave (
    input  logic                read_channel,     // Bus clock.
    input  logic                reset_i,          // Synchronous, active high.

    axi_write_if.slave          axi_wr,
    axi_read_if.slave           axi_rd,

    input  logic                stop_write_i,     // Hold off new writes.
    input  logic                stop_read_i,      // Hold off new reads.

    output logic                write_request_o,  // One cycle per accepted write.
    output axi_lite_pkg::addr_t write_address_o,
    output axi_lite_pkg::word_t write_data_o,
    output axi_lite_pkg::strb_t write_strobe_o,
    input  logic                write_done_i,
    input  logic                write_error_i,

    output logic                read_request_o,   // One cycle per accepted read.
    output axi_lite_pkg::addr_t read_address_o,
    input  axi_lite_pkg::word_t read_data_i,
    input  logic                read_valid_i,
    input  logic                read_error_i
);

    logic write_accept;   // AW and W taken on this edge.
    logic write_finish;   // B handshake on this edge.
    logic write_busy_q;
    logic write_busy_d;
    logic write_ready_q;  // Shared by AWREADY and WREADY.

    logic read_accept;
    logic read_finish;
    logic read_busy_q;
    logic read_busy_d;
    logic read_ready_q;

    // Address and data must arrive together.
    assign write_accept = axi_wr.awvalid & axi_wr.awready
                        & axi_wr.wvalid & axi_wr.wready;
    assign write_finish = axi_wr.bvalid & axi_wr.bready;

    // Busy from acceptance until the response is taken.
    always_comb begin
        write_busy_d = write_busy_q;
        if (write_accept) begin
            write_busy_d = 1'b1;
        end else if (write_finish) begin
            write_busy_d = 1'b0;
        end
    end

    always_ff @(posedge read_channel) begin : write_handshake
        if (reset_i) begin
            write_busy_q  <= 1'b0;
            write_ready_q <= 1'b1;  // Ready straight out of reset.
            axi_wr.bvalid <= 1'b0;
            axi_wr.bresp  <= axi_lite_pkg::OKAY;
        end else begin
            write_busy_q  <= write_busy_d;
            // Next-state busy, so ready falls right after acceptance.
            write_ready_q <= !(stop_write_i | write_busy_d);
            if (write_done_i) begin
                axi_wr.bvalid <= 1'b1;  // Bank finished the write.
                axi_wr.bresp  <= write_error_i ? axi_lite_pkg::SLVERR
                                               : axi_lite_pkg::OKAY;
            end else if (write_finish) begin
                axi_wr.bvalid <= 1'b0;  // Master took the response.
            end
        end
    end : write_handshake

    assign axi_wr.awready = write_ready_q;
    assign axi_wr.wready  = write_ready_q;

    // Request straight to the bank, same cycle as the handshake.
    assign write_request_o = write_accept;
    assign write_address_o = axi_wr.awaddr;
    assign write_data_o    = axi_wr.wdata;
    assign write_strobe_o  = axi_wr.wstrb;

    assign read_accept = axi_rd.arvalid & axi_rd.arready;
    assign read_finish = axi_rd.rvalid & axi_rd.rready;

    always_comb begin
        read_busy_d = read_busy_q;
        if (read_accept) begin
            read_busy_d = 1'b1;
        end else if (read_finish) begin
            read_busy_d = 1'b0;
        end
    end

    always_ff @(posedge read_channel) begin : read_handshake
        if (reset_i) begin
            read_busy_q   <= 1'b0;
            read_ready_q  <= 1'b1;
            axi_rd.rvalid <= 1'b0;
            axi_rd.rresp  <= axi_lite_pkg::OKAY;
        end else begin
            read_busy_q  <= read_busy_d;
            read_ready_q <= !(stop_read_i | read_busy_d);
            if (read_valid_i) begin
                axi_rd.rvalid <= 1'b1;  // Data from the bank is in.
                axi_rd.rresp  <= read_error_i ? axi_lite_pkg::SLVERR
                                              : axi_lite_pkg::OKAY;
            end else if (read_finish) begin
                axi_rd.rvalid <= 1'b0;
            end
        end
    end : read_handshake

    // Captured only with the bank's valid flag, stable while RVALID waits.
    always_ff @(posedge read_channel) begin : read_payload
        if (read_valid_i) begin
            axi_rd.rdata <= read_data_i;
        end
    end : read_payload

    assign axi_rd.arready = read_ready_q;

    assign read_request_o = read_accept;
    assign read_address_o = axi_rd.araddr;

endmodule

// File: src/reg_bank.sv
`timescale 1ns/1ps
`include "axi_lite_config.svh"

module reg_bank (
    input  logic                read_channel,     // Bus clock.
    input  logic                reset_i,

    input  logic                write_request_i,
    input  axi_lite_pkg::addr_t write_address_i,  // Byte address.
    input  axi_lite_pkg::word_t write_data_i,
    input  axi_lite_pkg::strb_t write_strobe_i,
    output logic                write_done_o,     // Single-cycle pulse.
    output logic                write_error_o,

    input  logic                read_request_i,
    input  axi_lite_pkg::addr_t read_address_i,
    output axi_lite_pkg::word_t read_data_o,
    output logic                read_valid_o,     // Single-cycle pulse.
    output logic                read_error_o
);

    // Word index is the byte address without its two low bits.
    localparam int unsigned IDX_BITS = `AXI_ADDR_WIDTH - 2;
    // Bits needed to select a stored word.
    localparam int unsigned SEL_BITS = (`AXI_REG_COUNT > 1) ? $clog2(`AXI_REG_COUNT) : 1;
    localparam int unsigned LANES    = $bits(axi_lite_pkg::strb_t);

    // Index 0 has no storage, it reads the ID word.
    axi_lite_pkg::word_t regs [1:`AXI_REG_COUNT-1];

    logic [IDX_BITS-1:0] write_index;
    logic [IDX_BITS-1:0] read_index;
    logic [SEL_BITS-1:0] write_sel;
    logic [SEL_BITS-1:0] read_sel;
    logic                write_bad;
    logic                read_bad;
    axi_lite_pkg::word_t read_word;

    assign write_index = write_address_i[`AXI_ADDR_WIDTH-1:2];
    assign read_index  = read_address_i[`AXI_ADDR_WIDTH-1:2];
    assign write_sel   = write_index[SEL_BITS-1:0];
    assign read_sel    = read_index[SEL_BITS-1:0];

    // Out of range, or the ID word.
    assign write_bad = (write_index >= IDX_BITS'(`AXI_REG_COUNT))
                     || (write_index == '0);
    assign read_bad  = (read_index >= IDX_BITS'(`AXI_REG_COUNT));

    // Read mux. Zero on error.
    always_comb begin
        if (read_bad) begin
            read_word = '0;
        end else if (read_index == '0) begin
            read_word = `AXI_ID_WORD;
        end else begin
            read_word = regs[read_sel];
        end
    end

    always_ff @(posedge read_channel) begin : storage
        if (reset_i) begin
            for (int i = 1; i < `AXI_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_request_i && !write_bad) begin
            // Merge under the byte strobes.
            for (int b = 0; b < LANES; b++) begin
                if (write_strobe_i[b]) begin
                    regs[write_sel][8*b +: 8] <= write_data_i[8*b +: 8];
                end
            end
        end
    end : storage

    always_ff @(posedge read_channel) begin : completion
        if (reset_i) begin
            write_done_o  <= 1'b0;
            write_error_o <= 1'b0;
            read_valid_o  <= 1'b0;
            read_error_o  <= 1'b0;
        end else begin
            write_done_o <= write_request_i;  // Done the edge after request.
            read_valid_o <= read_request_i;
            if (write_request_i) begin
                write_error_o <= write_bad;
            end
            if (read_request_i) begin
                read_error_o <= read_bad;
            end
        end
    end : completion

    // Data word, held until the next read.
    always_ff @(posedge read_channel) begin : read_capture
        if (read_request_i) begin
            read_data_o <= read_word;
        end
    end : read_capture

endmodule

// File: src/axi_periph_top.sv
`timescale 1ns/1ps

module axi_periph_top (
    input  logic                read_channel,   // Bus clock.
    input  logic                reset_i,        // Synchronous, active high.

    // Write address and data.
    input  axi_lite_pkg::addr_t awaddr_i,
    input  logic                awvalid_i,
    output logic                awready_o,
    input  axi_lite_pkg::word_t wdata_i,
    input  axi_lite_pkg::strb_t wstrb_i,
    input  logic                wvalid_i,
    output logic                wready_o,

    // Write response.
    output axi_lite_pkg::resp_t bresp_o,
    output logic                bvalid_o,
    input  logic                bready_i,

    // Read address.
    input  axi_lite_pkg::addr_t araddr_i,
    input  logic                arvalid_i,
    output logic                arready_o,

    // Read data.
    output axi_lite_pkg::word_t rdata_o,
    output axi_lite_pkg::resp_t rresp_o,
    output logic                rvalid_o,
    input  logic                rready_i,

    input  logic                stall_write_i,  // Back-pressure on AW and W.
    input  logic                stall_read_i    // Back-pressure on AR.
);

    // Slave to bank request and completion wires.
    logic                write_request;
    axi_lite_pkg::addr_t write_address;
    axi_lite_pkg::word_t write_data;
    axi_lite_pkg::strb_t write_strobe;
    logic                write_done;
    logic                write_error;
    logic                read_request;
    axi_lite_pkg::addr_t read_address;
    axi_lite_pkg::word_t read_data;
    logic                read_valid;
    logic                read_error;

    axi_write_if axi_wr ();
    axi_read_if  axi_rd ();

    // Master side of the write bundle.
    assign axi_wr.awaddr  = awaddr_i;
    assign axi_wr.awvalid = awvalid_i;
    assign axi_wr.wdata   = wdata_i;
    assign axi_wr.wstrb   = wstrb_i;
    assign axi_wr.wvalid  = wvalid_i;
    assign axi_wr.bready  = bready_i;
    assign awready_o      = axi_wr.awready;
    assign wready_o       = axi_wr.wready;
    assign bresp_o        = axi_wr.bresp;
    assign bvalid_o       = axi_wr.bvalid;

    // Master side of the read bundle.
    assign axi_rd.araddr  = araddr_i;
    assign axi_rd.arvalid = arvalid_i;
    assign axi_rd.rready  = rready_i;
    assign arready_o      = axi_rd.arready;
    assign rdata_o        = axi_rd.rdata;
    assign rresp_o        = axi_rd.rresp;
    assign rvalid_o       = axi_rd.rvalid;

    axi_slave u_slave (
        .read_channel    (read_channel),
        .reset_i         (reset_i),
        .axi_wr          (axi_wr.slave),
        .axi_rd          (axi_rd.slave),
        .stop_write_i    (stall_write_i),
        .stop_read_i     (stall_read_i),
        .write_request_o (write_request),
        .write_address_o (write_address),
        .write_data_o    (write_data),
        .write_strobe_o  (write_strobe),
        .write_done_i    (write_done),
        .write_error_i   (write_error),
        .read_request_o  (read_request),
        .read_address_o  (read_address),
        .read_data_i     (read_data),
        .read_valid_i    (read_valid),
        .read_error_i    (read_error)
    );

    reg_bank u_bank (
        .read_channel    (read_channel),
        .reset_i         (reset_i),
        .write_request_i (write_request),
        .write_address_i (write_address),
        .write_data_i    (write_data),
        .write_strobe_i  (write_strobe),
        .write_done_o    (write_done),
        .write_error_o   (write_error),
        .read_request_i  (read_request),
        .read_address_i  (read_address),
        .read_data_o     (read_data),
        .read_valid_o    (read_valid),
        .read_error_o    (read_error)
    );

endmodule

// File: sim/axi_periph_sva.sv
`timescale 1ns/1ps

// Handshake rules at the peripheral ports.
module axi_periph_sva (
    input logic                read_channel,
    input logic                reset_i,
    input logic                awready_i,
    input logic                arready_i,
    input logic                bvalid_i,
    input logic                bready_i,
    input axi_lite_pkg::resp_t bresp_i,
    input logic                rvalid_i,
    input logic                rready_i,
    input axi_lite_pkg::word_t rdata_i,
    input axi_lite_pkg::resp_t rresp_i
);

    // B response waits with BRESP held.
    b_hold: assert property (@(posedge read_channel) disable iff (reset_i)
        bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
        else $error("BVALID dropped or BRESP changed while BREADY was low");

    r_hold: assert property (@(posedge read_channel) disable iff (reset_i)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
        else $error("RVALID dropped or read payload changed while RREADY was low");

    // Address channels open straight out of reset.
    ready_after_reset: assert property (@(posedge read_channel)
        $fell(reset_i) |-> awready_i && arready_i)
        else $error("AWREADY or ARREADY low on the first cycle after reset");

endmodule

bind axi_periph_top axi_periph_sva u_sva (
    .read_channel (read_channel),
    .reset_i      (reset_i),
    .awready_i    (awready_o),
    .arready_i    (arready_o),
    .bvalid_i     (bvalid_o),
    .bready_i     (bready_i),
    .bresp_i      (bresp_o),
    .rvalid_i     (rvalid_o),
    .rready_i     (rready_i),
    .rdata_i      (rdata_o),
    .rresp_i      (rresp_o)
);

// File: sim/axi_periph_tb.sv
`timescale 1ns/1ps
`include "axi_lite_config.svh"

module axi_periph_tb;

    localparam int TIMEOUT  = 200;  // Cycles allowed per wait.
    localparam int SEL_BITS = $clog2(`AXI_REG_COUNT);

    logic read_channel, reset_i, stall_write_i, stall_read_i;
    logic awvalid_i, awready_o, wvalid_i, wready_o, bvalid_o, bready_i;
    logic arvalid_i, arready_o, rvalid_o, rready_i;
    axi_lite_pkg::addr_t awaddr_i, araddr_i;
    axi_lite_pkg::word_t wdata_i, rdata_o;
    axi_lite_pkg::strb_t wstrb_i;
    axi_lite_pkg::resp_t bresp_o, rresp_o;

    axi_lite_pkg::word_t model [0:`AXI_REG_COUNT-1];  // Expected bank contents.
    axi_lite_pkg::word_t exp_rdata [$];
    axi_lite_pkg::resp_t exp_rresp [$];
    axi_lite_pkg::resp_t exp_bresp [$];
    int   b_count   = 0;     // B handshakes seen.
    int   r_count   = 0;     // R handshakes seen.
    int   errors    = 0;
    int   timeouts  = 0;
    bit   bp_enable = 1'b0;  // Random ready and stall traffic on.
    logic stall_w_q = 1'b0;  // Stall inputs at the previous edge.
    logic stall_r_q = 1'b0;

    axi_periph_top UUT (.*);

    initial begin
        read_channel = 1'b0;
        forever #10 read_channel = ~read_channel;
    end

    // Predicted RDATA and RRESP for a byte address.
    function automatic void expect_read(input axi_lite_pkg::addr_t addr,
                                        output axi_lite_pkg::word_t data,
                                        output axi_lite_pkg::resp_t resp);
        axi_lite_pkg::addr_t idx;
        idx  = addr >> 2;
        data = '0;
        resp = axi_lite_pkg::OKAY;
        if (idx >= axi_lite_pkg::addr_t'(`AXI_REG_COUNT)) begin
            resp = axi_lite_pkg::SLVERR;  // Past the bank, data stays 0.
        end else if (idx == '0) begin
            data = `AXI_ID_WORD;
        end else begin
            data = model[idx[SEL_BITS-1:0]];
        end
    endfunction

    // Model update for one write, returns the predicted BRESP.
    function automatic axi_lite_pkg::resp_t apply_write(input axi_lite_pkg::addr_t addr,
                                                        input axi_lite_pkg::word_t data,
                                                        input axi_lite_pkg::strb_t strb);
        axi_lite_pkg::addr_t idx;
        axi_lite_pkg::word_t mask;
        idx  = addr >> 2;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        if (idx >= axi_lite_pkg::addr_t'(`AXI_REG_COUNT) || idx == '0) begin
            return axi_lite_pkg::SLVERR;  // ID word and holes untouched.
        end
        model[idx[SEL_BITS-1:0]] = (model[idx[SEL_BITS-1:0]] & ~mask) | (data & mask);
        return axi_lite_pkg::OKAY;
    endfunction

    task automatic finish_run();
        $display("Checks finished: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic abort_run(input string what);
        timeouts++;
        $display("Timeout while waiting for %s", what);
        finish_run();
    endtask

    // One falling edge of a bounded wait.
    task automatic step(inout int n, input string what);
        @(negedge read_channel);
        n++;
        if (n >= TIMEOUT) abort_run(what);
    endtask

    task automatic do_write(input axi_lite_pkg::addr_t addr,
                            input axi_lite_pkg::word_t data,
                            input axi_lite_pkg::strb_t strb);
        int n;
        int target;
        target    = b_count + 1;
        awaddr_i  = addr;
        wdata_i   = data;
        wstrb_i   = strb;
        awvalid_i = 1'b1;  // AW and W together.
        wvalid_i  = 1'b1;
        n = 0;
        while (!(awready_o && wready_o)) step(n, "AWREADY and WREADY");
        @(negedge read_channel);  // Accepted on the edge just passed.
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        exp_bresp.push_back(apply_write(addr, data, strb));
        n = 0;
        while (b_count < target) step(n, "the write response");
    endtask

    task automatic do_read(input axi_lite_pkg::addr_t addr);
        int n;
        int target;
        axi_lite_pkg::word_t data;
        axi_lite_pkg::resp_t resp;
        target    = r_count + 1;
        araddr_i  = addr;
        arvalid_i = 1'b1;
        n = 0;
        while (!arready_o) step(n, "ARREADY");
        @(negedge read_channel);
        arvalid_i = 1'b0;
        expect_read(addr, data, resp);
        exp_rdata.push_back(data);
        exp_rresp.push_back(resp);
        n = 0;
        while (r_count < target) step(n, "the read response");
    endtask

    // Checks every completed response and the ready rules.
    always @(posedge read_channel) begin : compare
        if (!reset_i) begin
            if (bvalid_o && bready_i) begin
                assert (exp_bresp.size() > 0) else begin
                    errors++;
                    $display("Write response arrived with no write outstanding");
                end
                if (exp_bresp.size() > 0) begin
                    assert (bresp_o == exp_bresp[0]) else begin
                        errors++;
                        $display("[ERROR] bresp_o = %h, expected %h", bresp_o, exp_bresp[0]);
                    end
                    void'(exp_bresp.pop_front());
                end
                b_count++;
            end
            if (rvalid_o && rready_i) begin
                assert (exp_rdata.size() > 0) else begin
                    errors++;
                    $display("Read response arrived with no read outstanding");
                end
                if (exp_rdata.size() > 0) begin
                    assert (rdata_o == exp_rdata[0] && rresp_o == exp_rresp[0]) else begin
                        errors++;
                        $display("[ERROR] rdata_o = %h rresp_o = %h, expected %h %h",
                                 rdata_o, rresp_o, exp_rdata[0], exp_rresp[0]);
                    end
                    void'(exp_rdata.pop_front());
                    void'(exp_rresp.pop_front());
                end
                r_count++;
            end
            // Waiting response blocks the address channel.
            assert (!(bvalid_o && !bready_i && (awready_o || wready_o))) else begin
                errors++;
                $display("[ERROR] awready_o = %h wready_o = %h while BVALID waits, expected 0 0",
                         awready_o, wready_o);
            end
            assert (!(rvalid_o && !rready_i && arready_o)) else begin
                errors++;
                $display("[ERROR] arready_o = %h while RVALID waits, expected 0", arready_o);
            end
            // Stall seen last edge means ready low now.
            assert (!(stall_w_q && (awready_o || wready_o))) else begin
                errors++;
                $display("[ERROR] awready_o = %h wready_o = %h after stall, expected 0 0",
                         awready_o, wready_o);
            end
            assert (!(stall_r_q && arready_o)) else begin
                errors++;
                $display("[ERROR] arready_o = %h after stall, expected 0", arready_o);
            end
        end
        stall_w_q = stall_write_i;
        stall_r_q = stall_read_i;
    end

    // Random BREADY/RREADY holds and stall pulses.
    initial begin : backpressure
        int hold_b;
        int hold_r;
        hold_b        = 0;
        hold_r        = 0;
        bready_i      = 1'b1;
        rready_i      = 1'b1;
        stall_write_i = 1'b0;
        stall_read_i  = 1'b0;
        forever begin
            @(negedge read_channel);
            if (hold_b > 0) hold_b--;
            else if (bp_enable && $urandom % 5 == 0) hold_b = 1 + $urandom % 4;
            if (hold_r > 0) hold_r--;
            else if (bp_enable && $urandom % 5 == 0) hold_r = 1 + $urandom % 4;
            bready_i      = (hold_b == 0);
            rready_i      = (hold_r == 0);
            stall_write_i = bp_enable && ($urandom % 8 == 0);  // One-cycle pulses.
            stall_read_i  = bp_enable && ($urandom % 8 == 0);
        end
    end

    initial begin : stimulus
        axi_lite_pkg::addr_t addr;
        axi_lite_pkg::strb_t strb;
        int wi;
        int ri;
        void'($urandom(32'h433e));
        model     = '{default: '0};
        reset_i   = 1'b1;
        awaddr_i  = '0;
        awvalid_i = 1'b0;
        wdata_i   = '0;
        wstrb_i   = '0;
        wvalid_i  = 1'b0;
        araddr_i  = '0;
        arvalid_i = 1'b0;
        repeat (3) @(negedge read_channel);
        reset_i = 1'b0;

        // Reset contents, ID word at index 0.
        for (int i = 0; i < `AXI_REG_COUNT; i++) begin
            do_read(axi_lite_pkg::addr_t'(i) << 2);
        end

        bp_enable = 1'b1;
        repeat (40) begin
            addr = axi_lite_pkg::addr_t'(1 + $urandom % (`AXI_REG_COUNT - 1)) << 2;
            strb = ($urandom % 2 == 0) ? 4'hF : 4'($urandom);  // Full or partial.
            do_write(addr, $urandom, strb);
            do_read(addr);
        end

        // Read-only ID word, then holes past the bank.
        do_write('0, $urandom, 4'hF);
        do_read('0);
        do_write(axi_lite_pkg::addr_t'(`AXI_REG_COUNT) << 2, $urandom, 4'hF);
        do_read(axi_lite_pkg::addr_t'(`AXI_REG_COUNT) << 2);
        do_read(32'h0000_4000);

        // Both channels in flight, different indices.
        repeat (10) begin
            wi = 1 + $urandom % (`AXI_REG_COUNT - 1);
            ri = wi % (`AXI_REG_COUNT - 1) + 1;
            fork
                do_write(axi_lite_pkg::addr_t'(wi) << 2, $urandom, 4'($urandom));
                do_read(axi_lite_pkg::addr_t'(ri) << 2);
            join
        end
        finish_run();
    end

endmodule

// File: all.f
+incdir+src
src/axi_lite_pkg.sv
src/axi_write_if.sv
src/axi_read_if.sv
src/axi_slave.sv
src/reg_bank.sv
src/axi_periph_top.sv
sim/axi_periph_sva.sv
sim/axi_periph_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module axi_periph_tb \
        -f all.f -Mdir obj_dir -o axi_periph_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/axi_periph_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
exit 0
